// File: design/sram_config.svh
`ifndef SRAM_CONFIG_SVH
`define SRAM_CONFIG_SVH

`default_nettype none

// Word address width of the SRAM array
// 10 bits give 1024 words, so 4 KB of byte address space
`define SRAM_ADDR_BITS 10

// Number of words, derived from the address width
`define SRAM_DEPTH (1 << `SRAM_ADDR_BITS)

// Data width of one SRAM word
`define SRAM_DATA_BITS 32

// One byte enable per byte lane
`define SRAM_BE_BITS (`SRAM_DATA_BITS / 8)

// Access time in clock cycles
// rd_n must stay low this many cycles before rdata is valid
`define SRAM_TAA_CYCLES 3

// Write pulse width in clock cycles
// The array commits the write on the last edge of the pulse
`define SRAM_WE_CYCLES 2

`default_nettype wire

`endif

// File: design/sram_pkg.sv
`include "sram_config.svh"
`default_nettype none

package sram_pkg;

  // AXI response codes used by the bridge
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    WRITE = 2'b01,
    READ  = 2'b10,
    DONE  = 2'b11
  } seq_state_t;

  // One SRAM access, issued by the AXI slave
  typedef struct packed {
    logic                       is_write;
    logic [`SRAM_ADDR_BITS-1:0] addr;
    logic [`SRAM_DATA_BITS-1:0] wdata;
    logic [`SRAM_BE_BITS-1:0]   be;
  } sram_req_t;

  // Result of one access
  // err marks a read of an unwritten word or a read strobe that was too short
  typedef struct packed {
    logic [`SRAM_DATA_BITS-1:0] rdata;
    logic                       err;
  } sram_rsp_t;

endpackage

`default_nettype wire

// File: design/sram_bus_if.sv
`timescale 1ns/10ps
`include "sram_config.svh"
`default_nettype none

// SRAM pin bundle, all strobes active low
interface sram_bus_if;

  logic                       ce_n;
  logic                       we_n;
  logic                       rd_n;
  logic [`SRAM_ADDR_BITS-1:0] addr;
  logic [`SRAM_BE_BITS-1:0]   be;
  logic [`SRAM_DATA_BITS-1:0] wdata;
  logic [`SRAM_DATA_BITS-1:0] rdata;
  logic                       rerr;

  // Sequencer side
  modport controller (
    output ce_n, we_n, rd_n, addr, be, wdata,
    input  rdata, rerr
  );

  // Memory side
  modport memory (
    input  ce_n, we_n, rd_n, addr, be, wdata,
    output rdata, rerr
  );

endinterface

`default_nettype wire

// File: design/axil_sram_slave.sv
`timescale 1ns/10ps
`include "sram_config.svh"
`default_nettype none

module axil_sram_slave (
  input  logic                       oe_n,
  input  logic                       rst,
  // Write address channel
  input  logic [31:0]                awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  // Write data channel
  input  logic [`SRAM_DATA_BITS-1:0] wdata,
  input  logic [`SRAM_BE_BITS-1:0]   wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  // Write response channel
  output sram_pkg::axi_resp_t        bresp,
  output logic                       bvalid,
  input  logic                       bready,
  // Read address channel
  input  logic [31:0]                araddr,
  input  logic                       arvalid,
  output logic                       arready,
  // Read data channel
  output logic [`SRAM_DATA_BITS-1:0] rdata,
  output sram_pkg::axi_resp_t        rresp,
  output logic                       rvalid,
  input  logic                       rready,
  // Sequencer side
  output logic                       req_valid,
  output sram_pkg::sram_req_t        req,
  input  logic                       done,
  input  sram_pkg::sram_rsp_t        rsp
);
  import sram_pkg::*;

  // First byte address bit above the memory
  localparam int ADDR_HI = `SRAM_ADDR_BITS + 2;

  logic busy;
  logic idle;
  logic wr_go;
  logic rd_go;
  logic aw_in_range;
  logic ar_in_range;
  // Out-of-range access waiting one cycle for its response
  logic oor_q;

  // Idle only when nothing is in flight and no response is pending
  assign idle = !busy && !bvalid && !rvalid;

  // Write pair wins over a read in the same cycle
  assign wr_go = idle && awvalid && wvalid;
  assign rd_go = idle && arvalid && !(awvalid && wvalid);

  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;

  // Any bit above the word range set means out of range
  assign aw_in_range = (awaddr[31:ADDR_HI] == '0);
  assign ar_in_range = (araddr[31:ADDR_HI] == '0);

  always_ff @(posedge oe_n) begin
    if (rst) begin
      busy      <= 1'b0;
      req_valid <= 1'b0;
      oor_q     <= 1'b0;
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
    end else begin
      req_valid <= 1'b0;
      oor_q     <= 1'b0;
      if (wr_go) begin
        busy <= 1'b1;
        if (aw_in_range) begin
          req_valid <= 1'b1;
        end else begin
          // Answered here without an SRAM access
          oor_q <= 1'b1;
        end
      end else if (rd_go) begin
        busy <= 1'b1;
        if (ar_in_range) begin
          req_valid <= 1'b1;
        end else begin
          oor_q <= 1'b1;
        end
      end
      if (done || oor_q) begin
        busy <= 1'b0;
        if (req.is_write) begin
          bvalid <= 1'b1;
        end else begin
          rvalid <= 1'b1;
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Request and response payload
  always_ff @(posedge oe_n) begin
    if (wr_go) begin
      req.is_write <= 1'b1;
      req.addr     <= awaddr[ADDR_HI-1:2];
      req.wdata    <= wdata;
      req.be       <= wstrb;
      bresp        <= aw_in_range ? OKAY : SLVERR;
    end else if (rd_go) begin
      req.is_write <= 1'b0;
      req.addr     <= araddr[ADDR_HI-1:2];
      req.wdata    <= '0;
      req.be       <= '0;
      rresp        <= SLVERR;
      rdata        <= '0;
    end
    if (done && !req.is_write) begin
      rresp <= rsp.err ? SLVERR : OKAY;
      rdata <= rsp.rdata;
    end
  end

endmodule

`default_nettype wire

// File: design/sram_timing_ctrl.sv
`timescale 1ns/10ps
`include "sram_config.svh"
`default_nettype none

module sram_timing_ctrl (
  input  logic                oe_n,
  input  logic                rst,
  input  logic                req_valid,
  input  sram_pkg::sram_req_t req,
  output logic                done,
  output sram_pkg::sram_rsp_t rsp,
  sram_bus_if.controller      bus
);
  import sram_pkg::*;

  localparam int MAX_CYC = (`SRAM_TAA_CYCLES > `SRAM_WE_CYCLES) ?
                           `SRAM_TAA_CYCLES : `SRAM_WE_CYCLES;
  localparam int CNT_W = $clog2(MAX_CYC + 1);

  // Counter values on the last edge of each strobe
  localparam logic [CNT_W-1:0] WE_LAST  = CNT_W'(`SRAM_WE_CYCLES - 1);
  localparam logic [CNT_W-1:0] TAA_LAST = CNT_W'(`SRAM_TAA_CYCLES - 1);

  seq_state_t       state;
  logic [CNT_W-1:0] cyc_cnt;
  sram_req_t        req_q;

  always_ff @(posedge oe_n) begin
    if (rst) begin
      state   <= IDLE;
      cyc_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_valid) begin
            state   <= req.is_write ? WRITE : READ;
            cyc_cnt <= '0;
          end
        end
        WRITE: begin
          if (cyc_cnt == WE_LAST) begin
            state <= DONE;
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        READ: begin
          if (cyc_cnt == TAA_LAST) begin
            state <= DONE;
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address and data are latched once and held for the whole strobe
  always_ff @(posedge oe_n) begin
    if (state == IDLE && req_valid) begin
      req_q <= req;
    end
    if (state == READ && cyc_cnt == TAA_LAST) begin
      rsp.rdata <= bus.rdata;
      rsp.err   <= bus.rerr;
    end else if (state == WRITE && cyc_cnt == WE_LAST) begin
      rsp <= '0;
    end
  end

  assign bus.ce_n  = !(state == WRITE || state == READ);
  assign bus.we_n  = (state != WRITE);
  assign bus.rd_n  = (state != READ);
  assign bus.addr  = req_q.addr;
  assign bus.wdata = req_q.wdata;
  assign bus.be    = req_q.be;

  assign done = (state == DONE);

endmodule

`default_nettype wire

// File: design/sram_array.sv
`timescale 1ns/10ps
`include "sram_config.svh"
`default_nettype none

module sram_array (
  input logic        oe_n,
  input logic        rst,
  sram_bus_if.memory bus
);

  localparam int DEPTH   = `SRAM_DEPTH;
  localparam int MAX_CYC = (`SRAM_TAA_CYCLES > `SRAM_WE_CYCLES) ?
                           `SRAM_TAA_CYCLES : `SRAM_WE_CYCLES;
  localparam int CNT_W   = $clog2(MAX_CYC + 1);

  localparam logic [CNT_W-1:0] WE_LAST  = CNT_W'(`SRAM_WE_CYCLES - 1);
  localparam logic [CNT_W-1:0] TAA_LAST = CNT_W'(`SRAM_TAA_CYCLES - 1);

  logic [`SRAM_DATA_BITS-1:0] mem [DEPTH];
  logic [DEPTH-1:0]           written;
  logic [CNT_W-1:0]           wr_cnt;
  logic [CNT_W-1:0]           rd_cnt;
  logic [`SRAM_ADDR_BITS-1:0] rd_addr;
  logic                       wr_low;
  logic                       rd_low;
  logic                       wr_commit;
  logic                       rd_ready;
  logic                       rd_hit;

  assign wr_low = !bus.ce_n && !bus.we_n;
  assign rd_low = !bus.ce_n && !bus.rd_n;

  // Last cycle of the write pulse
  assign wr_commit = wr_low && (wr_cnt == WE_LAST);

  // Access time met with a stable address
  assign rd_ready = rd_low && (rd_cnt == TAA_LAST) &&
                    (rd_cnt == '0 || bus.addr == rd_addr);
  assign rd_hit   = rd_ready && written[bus.addr];

  always_ff @(posedge oe_n) begin
    if (rst) begin
      wr_cnt  <= '0;
      rd_cnt  <= '0;
      written <= '0;
    end else begin
      if (!wr_low) begin
        wr_cnt <= '0;
      end else if (wr_cnt != WE_LAST) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      // An address change restarts the access time
      if (!rd_low || (rd_cnt != '0 && bus.addr != rd_addr)) begin
        rd_cnt <= '0;
      end else if (rd_cnt != TAA_LAST) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
      if (wr_commit) begin
        written[bus.addr] <= 1'b1;
      end
    end
  end

  // Byte-lane writes into storage
  always_ff @(posedge oe_n) begin
    rd_addr <= bus.addr;
    if (wr_commit) begin
      for (int b = 0; b < `SRAM_BE_BITS; b++) begin
        if (bus.be[b]) begin
          mem[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // All ones and an error until the data is valid and known
  assign bus.rdata = rd_hit ? mem[bus.addr] : '1;
  assign bus.rerr  = !rd_hit;

endmodule

`default_nettype wire

// File: design/sram_subsystem_top.sv
`timescale 1ns/10ps
`include "sram_config.svh"
`default_nettype none

module sram_subsystem_top (
  input  logic                       oe_n,
  input  logic                       rst,
  input  logic [31:0]                awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [`SRAM_DATA_BITS-1:0] wdata,
  input  logic [`SRAM_BE_BITS-1:0]   wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output sram_pkg::axi_resp_t        bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [31:0]                araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [`SRAM_DATA_BITS-1:0] rdata,
  output sram_pkg::axi_resp_t        rresp,
  output logic                       rvalid,
  input  logic                       rready
);
  import sram_pkg::*;

  logic      req_valid;
  sram_req_t req;
  logic      done;
  sram_rsp_t rsp;

  // SRAM pins between sequencer and array
  sram_bus_if u_bus ();

  axil_sram_slave u_slave (
    .oe_n      (oe_n),
    .rst       (rst),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .req_valid (req_valid),
    .req       (req),
    .done      (done),
    .rsp       (rsp)
  );

  sram_timing_ctrl u_ctrl (
    .oe_n      (oe_n),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .done      (done),
    .rsp       (rsp),
    .bus       (u_bus)
  );

  sram_array u_array (
    .oe_n (oe_n),
    .rst  (rst),
    .bus  (u_bus)
  );

endmodule

`default_nettype wire

// File: verif/tb_sram_subsystem.sv
`timescale 1ns/10ps
`include "sram_config.svh"
`default_nettype none

module tb_sram_subsystem;
  import sram_pkg::*;

  localparam int DEPTH     = `SRAM_DEPTH;
  localparam int MAX_DELAY = 6;
  localparam int N_RANDOM  = 40;

  logic        oe_n;
  logic        rst;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  axi_resp_t   bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  axi_resp_t   rresp;
  logic        rvalid;
  logic        rready;

  // Stimulus table with one queue per column
  string       name_q[$];
  bit          wr_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [3:0]  strb_q[$];
  int          delay_q[$];
  axi_resp_t   resp_q[$];
  logic [31:0] exp_q[$];

  // Reference memory
  logic [31:0] ref_mem [DEPTH];
  bit          ref_written [DEPTH];

  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 1000;

  sram_subsystem_top i_dut (
    .oe_n    (oe_n),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  always #4 oe_n = ~oe_n;

  always @(posedge oe_n) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  task automatic check(string name, string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
      $display("Done: errors found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // New requests offered while a response is stalled must not be taken
  task automatic offer_requests(logic on);
    awvalid <= on;
    wvalid  <= on;
    arvalid <= on;
  endtask

  function automatic bit in_range(logic [31:0] addr);
    return (addr >> (`SRAM_ADDR_BITS + 2)) == 0;
  endfunction

  // Adds a write and updates the reference memory in table order
  function automatic void add_write(string name, logic [31:0] addr, logic [31:0] data,
                                    logic [3:0] strb, int delay);
    int widx;
    widx = addr[`SRAM_ADDR_BITS+1:2];
    name_q.push_back(name);
    wr_q.push_back(1'b1);
    addr_q.push_back(addr);
    data_q.push_back(data);
    strb_q.push_back(strb);
    delay_q.push_back(delay);
    exp_q.push_back('0);
    if (in_range(addr)) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          ref_mem[widx][8*b +: 8] = data[8*b +: 8];
        end
      end
      ref_written[widx] = 1'b1;
      resp_q.push_back(OKAY);
    end else begin
      resp_q.push_back(SLVERR);
    end
  endfunction

  function automatic void add_read(string name, logic [31:0] addr, int delay);
    int widx;
    widx = addr[`SRAM_ADDR_BITS+1:2];
    name_q.push_back(name);
    wr_q.push_back(1'b0);
    addr_q.push_back(addr);
    data_q.push_back('0);
    strb_q.push_back('0);
    delay_q.push_back(delay);
    if (!in_range(addr)) begin
      resp_q.push_back(SLVERR);
      exp_q.push_back('0);
    end else if (ref_written[widx]) begin
      resp_q.push_back(OKAY);
      exp_q.push_back(ref_mem[widx]);
    end else begin
      // Unwritten word reads back as all ones
      resp_q.push_back(SLVERR);
      exp_q.push_back('1);
    end
  endfunction

  task automatic run_write(int idx);
    int        lat;
    int        exp_lat;
    axi_resp_t resp;
    exp_lat = in_range(addr_q[idx]) ? `SRAM_WE_CYCLES + 2 : 1;
    @(posedge oe_n);
    awaddr  <= addr_q[idx];
    awvalid <= 1'b1;
    wdata   <= data_q[idx];
    wstrb   <= strb_q[idx];
    wvalid  <= 1'b1;
    bready  <= (delay_q[idx] == 0);
    do @(negedge oe_n); while (!(awready && wready));
    // Handshake edge
    @(posedge oe_n);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    lat = 0;
    @(negedge oe_n);
    while (!bvalid) begin
      lat++;
      @(negedge oe_n);
    end
    resp = bresp;
    check(name_q[idx], "bresp", 32'(resp_q[idx]), 32'(resp));
    check(name_q[idx], "write latency", exp_lat, lat);
    repeat (delay_q[idx]) begin
      @(posedge oe_n);
      offer_requests(1'b1);
      @(negedge oe_n);
      check(name_q[idx], "bvalid held", 1, bvalid);
      check(name_q[idx], "bresp held", 32'(resp), 32'(bresp));
      check(name_q[idx], "ready while stalled", 0, {awready, wready, arready});
    end
    if (delay_q[idx] != 0) begin
      @(posedge oe_n);
      offer_requests(1'b0);
      bready <= 1'b1;
    end
    @(posedge oe_n);
    bready <= 1'b0;
    @(negedge oe_n);
    check(name_q[idx], "bvalid after accept", 0, bvalid);
  endtask

  task automatic run_read(int idx);
    int          lat;
    int          exp_lat;
    axi_resp_t   resp;
    logic [31:0] data;
    exp_lat = in_range(addr_q[idx]) ? `SRAM_TAA_CYCLES + 2 : 1;
    @(posedge oe_n);
    araddr  <= addr_q[idx];
    arvalid <= 1'b1;
    rready  <= (delay_q[idx] == 0);
    do @(negedge oe_n); while (!arready);
    @(posedge oe_n);
    arvalid <= 1'b0;
    lat = 0;
    @(negedge oe_n);
    while (!rvalid) begin
      lat++;
      @(negedge oe_n);
    end
    resp = rresp;
    data = rdata;
    check(name_q[idx], "rresp", 32'(resp_q[idx]), 32'(resp));
    check(name_q[idx], "rdata", exp_q[idx], data);
    check(name_q[idx], "read latency", exp_lat, lat);
    repeat (delay_q[idx]) begin
      @(posedge oe_n);
      offer_requests(1'b1);
      @(negedge oe_n);
      check(name_q[idx], "rvalid held", 1, rvalid);
      check(name_q[idx], "rresp held", 32'(resp), 32'(rresp));
      check(name_q[idx], "rdata held", data, rdata);
      check(name_q[idx], "ready while stalled", 0, {awready, wready, arready});
    end
    if (delay_q[idx] != 0) begin
      @(posedge oe_n);
      offer_requests(1'b0);
      rready <= 1'b1;
    end
    @(posedge oe_n);
    rready <= 1'b0;
    @(negedge oe_n);
    check(name_q[idx], "rvalid after accept", 0, rvalid);
  endtask

  initial begin
    int         widx;
    logic [3:0] strb;
    oe_n    = 1'b0;
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    void'($urandom(32'h26a6));

    // Directed entries
    add_write("full_wr_0", 32'h0000_0000, 32'hdead_beef, 4'hf, 0);
    add_read("full_rd_0", 32'h0000_0000, 0);
    add_write("full_wr_top", 32'h0000_0ffc, 32'h0123_4567, 4'hf, 2);
    add_read("full_rd_top", 32'h0000_0ffc, 3);
    add_write("part_base", 32'h0000_0010, 32'h1122_3344, 4'hf, 0);
    add_write("part_lo", 32'h0000_0010, 32'haabb_ccdd, 4'b0101, 0);
    add_read("part_rd1", 32'h0000_0010, 0);
    add_write("part_hi", 32'h0000_0010, 32'h5566_7788, 4'b1000, 1);
    add_read("part_rd2", 32'h0000_0010, 4);
    add_read("unwritten_rd", 32'h0000_0800, 0);
    add_write("oor_wr", 32'h0000_1000, 32'hcafe_f00d, 4'hf, 0);
    add_read("oor_rd_word0", 32'h0000_0000, 0);
    add_read("oor_rd", 32'h0000_1000, 2);
    add_read("oor_rd_far", 32'h8000_0000, 0);
    add_write("oor_wr_far", 32'hffff_fffc, 32'h1234_5678, 4'hf, 5);
    add_write("stall_wr", 32'h0000_0020, 32'h0f0f_a5a5, 4'hf, MAX_DELAY);
    add_read("stall_rd", 32'h0000_0020, MAX_DELAY);

    // Random mix on a small word window so reads hit earlier writes
    for (int i = 0; i < N_RANDOM; i++) begin
      widx = $urandom_range(0, 31);
      if ($urandom_range(0, 1) == 1) begin
        // Partial strobes only on words that already hold data
        strb = ref_written[widx] ? 4'($urandom_range(1, 15)) : 4'hf;
        add_write($sformatf("rand_wr_%0d", i), 32'(widx) << 2, $urandom, strb,
                  $urandom_range(0, MAX_DELAY));
      end else begin
        add_read($sformatf("rand_rd_%0d", i), 32'(widx) << 2,
                 $urandom_range(0, MAX_DELAY));
      end
    end

    cycle_limit = name_q.size() * (`SRAM_TAA_CYCLES + 2 + MAX_DELAY + 4) + 100;

    repeat (4) @(posedge oe_n);
    rst <= 1'b0;

    foreach (name_q[i]) begin
      if (wr_q[i]) begin
        run_write(i);
      end else begin
        run_read(i);
      end
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/sram_pkg.sv
design/sram_bus_if.sv
design/axil_sram_slave.sv
design/sram_timing_ctrl.sv
design/sram_array.sv
design/sram_subsystem_top.sv
verif/tb_sram_subsystem.sv
